/* build.f */
+incdir+.
uart_cmd_pkg.sv
uart_line_pkg.sv
cmd_axil_slave.sv
cmd_fifo.sv
uart_cmd_engine.sv
uart_line_tx.sv
uart_line_rx.sv
uart_cmd_top.sv
tb_uart_cmd.sv

/* cmd_axil_slave.sv */
`timescale 1ns/1ps
`include "uart_cmd_defs.svh"

module cmd_axil_slave (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     awvalid,
  input  logic [3:0]               awaddr,
  output logic                     awready,
  input  logic                     wvalid,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,   // byte strobes are ignored, a command is a full word
  output logic                     wready,
  output logic                     bvalid,
  output uart_cmd_pkg::axil_resp_e bresp,
  input  logic                     bready,
  input  logic                     arvalid,
  input  logic [3:0]               araddr,
  output logic                     arready,
  output logic                     rvalid,
  output logic [31:0]              rdata,
  output uart_cmd_pkg::axil_resp_e rresp,
  input  logic                     rready,
  output logic                     cmd_valid,
  output uart_cmd_pkg::cmd_t       cmd,
  input  logic                     cmd_ready,
  input  logic                     rsp_valid,
  input  uart_cmd_pkg::rsp_t       rsp,
  output logic                     rsp_ready,
  input  logic                     busy
);
  import uart_cmd_pkg::*;

  logic wr_pair;
  logic wr_is_cmd;
  logic wr_accept;
  logic rd_accept;
  logic rsp_held;
  rsp_t rsp_q;

  // write channels ------------------------
  assign wr_pair   = awvalid && wvalid && !bvalid;   // AW and W are taken together
  assign wr_is_cmd = (awaddr == `UART_REG_CMD);
  assign wr_accept = wr_pair && (!wr_is_cmd || cmd_ready);
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign cmd_valid = wr_pair && wr_is_cmd;
  assign cmd       = cmd_t'(wdata[15:0]);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bvalid <= 1'b0;
      bresp  <= RESP_OKAY;
    end
    else if (wr_accept)
    begin
      bvalid <= 1'b1;
      bresp  <= wr_is_cmd ? RESP_OKAY : RESP_SLVERR;
    end
    else if (bready)
      bvalid <= 1'b0;
  end

  // read channels -------------------------
  assign rd_accept = arvalid && !rvalid;
  assign arready   = rd_accept;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rvalid <= 1'b0;
      rdata  <= '0;
      rresp  <= RESP_OKAY;
    end
    else if (rd_accept)
    begin
      rvalid <= 1'b1;
      rresp  <= RESP_OKAY;
      case (araddr)
        `UART_REG_RSP:  rdata <= {22'd0, rsp_q};
        `UART_REG_STAT: rdata <= {30'd0, busy, rsp_held};
        default:
        begin
          rdata <= '0;
          rresp <= RESP_SLVERR;
        end
      endcase
    end
    else if (rready)
      rvalid <= 1'b0;
  end

  // one response is kept until the host reads it, and the engine waits meanwhile
  assign rsp_ready = !rsp_held;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rsp_held <= 1'b0;
    else if (rsp_valid && rsp_ready)
      rsp_held <= 1'b1;
    else if (rd_accept && araddr == `UART_REG_RSP)
      rsp_held <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rsp_valid && rsp_ready)
      rsp_q <= rsp;
  end

endmodule

/* cmd_fifo.sv */
`timescale 1ns/1ps
`include "uart_cmd_defs.svh"

module cmd_fifo (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  uart_cmd_pkg::cmd_t in_data,
  output logic               out_valid,
  input  logic               out_ready,
  output uart_cmd_pkg::cmd_t out_data
);
  import uart_cmd_pkg::*;

  localparam int DEPTH = `UART_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  cmd_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign out_valid = (count != '0);
  assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready;   // a pop frees the slot of a full buffer
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

endmodule

/* tb_uart_cmd.sv */
`timescale 1ns/1ps
`include "uart_cmd_defs.svh"

module tb_uart_cmd;
  import uart_cmd_pkg::*;
  import uart_line_pkg::*;

  localparam int MAX_LINES  = 16;
  localparam int FIELDS     = 7;
  localparam int WAIT_LIMIT = 4000;    // clocks
  localparam int POLL_LIMIT = 500;     // status reads
  localparam int IDLE_LIMIT = 20000;   // clocks of idle tx
  localparam logic [15:0] KIND_WRITE = 16'h0;
  localparam logic [15:0] KIND_READ  = 16'h1;
  localparam logic [15:0] KIND_BAD   = 16'h2;
  localparam logic [15:0] KIND_BURST = 16'h3;
  localparam logic [15:0] KIND_END   = 16'hf;
  localparam logic [15:0] MODE_BAD_PARITY = 16'h1;
  localparam logic [15:0] MODE_NONE  = 16'h2;

  logic        clk;
  logic        rst_n;
  logic        awvalid;
  logic [3:0]  awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wready;
  logic        bvalid;
  axil_resp_e  bresp;
  logic        bready;
  logic        arvalid;
  logic [3:0]  araddr;
  logic        arready;
  logic        rvalid;
  logic [31:0] rdata;
  axil_resp_e  rresp;
  logic        rready;
  logic        rx;
  logic        tx;

  logic [15:0] vec [0:MAX_LINES*FIELDS-1];
  rx_byte_t    frame_q [$];   // frames seen on tx
  rx_byte_t    exp_q [$];     // frames still owed by queued writes

  uart_cmd_top i_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic rx_byte_t make_frame(input logic [7:0] data);
    rx_byte_t frame;
    frame.data      = data;
    frame.parity_ok = 1'b1;   // every frame on tx must carry odd parity
    return frame;
  endfunction

  // compare tasks ---------------------------
  task automatic check_frame(input string name, input rx_byte_t got, input rx_byte_t exp);
    if (got !== exp)
      fail_with($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_rsp(input string name, input rsp_t got, input rsp_t exp);
    if (got !== exp)
      fail_with($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_axil_resp(input string name, input axil_resp_e got,
                                 input axil_resp_e exp);
    if (got !== exp)
      fail_with($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp)
      fail_with($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  // AXI4-Lite host --------------------------
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output axil_resp_e resp);
    int waited;
    int stall;
    waited  = 0;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = 4'hf;
    @(negedge clk);
    while (!(awready && wready))
    begin
      waited++;
      if (waited > WAIT_LIMIT)
        fail_with("the write address and data were never accepted");
      @(negedge clk);
    end
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    stall   = $urandom_range(0, 4);
    repeat (stall) next_cycle();
    bready = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!bvalid)
    begin
      waited++;
      if (waited > WAIT_LIMIT)
        fail_with("no write response came back");
      @(negedge clk);
    end
    resp = bresp;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output axil_resp_e resp);
    int waited;
    int stall;
    waited  = 0;
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk);
    while (!arready)
    begin
      waited++;
      if (waited > WAIT_LIMIT)
        fail_with("the read address was never accepted");
      @(negedge clk);
    end
    next_cycle();
    arvalid = 1'b0;
    stall   = $urandom_range(0, 4);
    repeat (stall) next_cycle();
    rready = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!rvalid)
    begin
      waited++;
      if (waited > WAIT_LIMIT)
        fail_with("no read data came back");
      @(negedge clk);
    end
    data = rdata;
    resp = rresp;
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic wait_status(input logic [31:0] mask, input logic [31:0] want,
                             input string what);
    int          polls;
    logic [31:0] word;
    axil_resp_e  resp;
    polls = 0;
    axil_read(`UART_REG_STAT, word, resp);
    check_axil_resp("rresp", resp, RESP_OKAY);
    while ((word & mask) != want)
    begin
      polls++;
      if (polls > POLL_LIMIT)
        fail_with($sformatf("status register never showed %s", what));
      axil_read(`UART_REG_STAT, word, resp);
      check_axil_resp("rresp", resp, RESP_OKAY);
    end
  endtask

  // serial device model -----------------------
  task automatic monitor_tx();
    logic [9:0] bits;
    rx_byte_t   frame;
    int         idle;
    forever
    begin
      idle = 0;
      @(negedge clk);
      while (tx !== 1'b0)
      begin
        idle++;
        if (idle > IDLE_LIMIT)
          fail_with("tx stayed idle far too long");
        @(negedge clk);
      end
      repeat (`UART_BAUD_DIV / 2 - 1) @(negedge clk);   // now at the middle of the start bit
      if (tx !== 1'b0)
        fail_with("start bit on tx did not last to mid-bit");
      for (int i = 0; i < 10; i++)
      begin
        repeat (`UART_BAUD_DIV) @(negedge clk);
        bits[i] = tx;
      end
      if (bits[9] !== 1'b1)
        fail_with("stop bit on tx was low");
      frame.data      = bits[7:0];
      frame.parity_ok = ^bits[8:0];   // odd count of ones over data and parity
      frame_q.push_back(frame);
    end
  endtask

  task automatic drive_reply(input logic [7:0] data, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    repeat (10) next_cycle();
    for (int i = 0; i < 11; i++)
    begin
      rx = bits[i];   // start, data LSB first, parity, stop
      repeat (`UART_BAUD_DIV) next_cycle();
    end
  endtask

  task automatic wait_frames(input int n);
    int waited;
    waited = 0;
    while (frame_q.size() < n)
    begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT)
        fail_with($sformatf("timed out waiting for %0d frames on tx", n));
    end
  endtask

  // frames of queued writes must come out in issue order
  task automatic drain_writes();
    logic [31:0] word;
    axil_resp_e  resp;
    if (exp_q.size() != 0)
    begin
      axil_read(`UART_REG_STAT, word, resp);
      check_axil_resp("rresp", resp, RESP_OKAY);
      if (word[1] !== 1'b1)
        fail_with("status busy bit was low while writes were still pending");
      wait_frames(exp_q.size());
      while (exp_q.size() != 0)
        check_frame("tx frame", frame_q.pop_front(), exp_q.pop_front());
      wait_status(32'h3, 32'h0, "idle after writes");
      if (frame_q.size() != 0)
        fail_with("an extra frame appeared on tx after the writes");
    end
  endtask

  // ----------------------------------------
  initial
  begin
    logic [15:0] kind;
    logic [15:0] cmd_word;
    logic [15:0] reply;
    logic [15:0] mode;
    logic [15:0] exp_data;
    logic [15:0] exp_status;
    axil_resp_e  exp_resp;
    rsp_t        exp_rsp;
    logic [31:0] word;
    axil_resp_e  resp;
    int          base;
    void'($urandom(26));
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    rx      = 1'b1;
    $readmemh("uart_cmd_input.txt", vec);
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fork
      monitor_tx();
    join_none
    next_cycle();

    for (int idx = 0; idx < MAX_LINES; idx++)
    begin
      base       = idx * FIELDS;
      kind       = vec[base];
      cmd_word   = vec[base + 1];
      reply      = vec[base + 2];
      mode       = vec[base + 3];
      exp_data   = vec[base + 4];
      exp_status = vec[base + 5];
      exp_resp   = axil_resp_e'(vec[base + 6][1:0]);
      if ($isunknown(kind))
        fail_with("stimulus file is missing or has an unreadable line");
      if (kind == KIND_END)
        break;
      if (kind != KIND_BURST)
        drain_writes();
      case (kind)
        KIND_WRITE, KIND_BURST:
        begin
          axil_write(`UART_REG_CMD, {16'd0, cmd_word}, resp);
          check_axil_resp("bresp", resp, exp_resp);
          exp_q.push_back(make_frame({1'b1, cmd_word[14:8]}));   // header is {op, addr}
          exp_q.push_back(make_frame(cmd_word[7:0]));
          if (kind == KIND_WRITE)
            drain_writes();
        end
        KIND_READ:
        begin
          axil_write(`UART_REG_CMD, {16'd0, cmd_word}, resp);
          check_axil_resp("bresp", resp, exp_resp);
          wait_frames(1);
          check_frame("tx header", frame_q.pop_front(), make_frame({1'b0, cmd_word[14:8]}));
          if (mode != MODE_NONE)
            drive_reply(reply[7:0], mode == MODE_BAD_PARITY);
          wait_status(32'h1, 32'h1, "a held response");
          if (frame_q.size() != 0)
            fail_with("a read sent more than one frame on tx");
          axil_read(`UART_REG_RSP, word, resp);
          check_axil_resp("rresp", resp, exp_resp);
          exp_rsp.status = rsp_status_e'(exp_status[1:0]);
          exp_rsp.rdata  = exp_data[7:0];
          check_rsp("rsp", rsp_t'(word[9:0]), exp_rsp);
        end
        KIND_BAD:
        begin
          axil_write(4'hc, {16'd0, cmd_word}, resp);
          check_axil_resp("bresp", resp, exp_resp);
          axil_read(4'hc, word, resp);
          check_axil_resp("rresp", resp, exp_resp);
          check_word("rdata", word, {16'd0, exp_data});
          repeat (3 * 11 * `UART_BAUD_DIV) next_cycle();   // room for a frame that must not come
          if (frame_q.size() != 0 || tx !== 1'b1)
            fail_with("an access to an unmapped offset started a frame on tx");
        end
        default:
          fail_with("stimulus file holds an unknown command kind");
      endcase
    end
    drain_writes();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* uart_cmd_defs.svh */
`ifndef UART_CMD_DEFS_SVH
`define UART_CMD_DEFS_SVH

// serial line timing in clock cycles
`define UART_BAUD_DIV    8     // clocks per bit
`define UART_GAP_CYCLES  16    // idle clocks after each transmitted command
`define UART_RX_TIMEOUT  400   // clocks from end of read header to reply start bit

`define UART_FIFO_DEPTH  4

// byte offsets of the host registers
`define UART_REG_CMD     4'h0
`define UART_REG_RSP     4'h4
`define UART_REG_STAT    4'h8

`endif

/* uart_cmd_engine.sv */
`timescale 1ns/1ps
`include "uart_cmd_defs.svh"

module uart_cmd_engine (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  uart_cmd_pkg::cmd_t      cmd,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output uart_cmd_pkg::rsp_t      rsp,
  output logic                    tx_start,
  output logic [7:0]              tx_byte,
  input  logic                    tx_ready,
  input  logic                    tx_done,
  input  logic                    rx_busy,
  input  logic                    rx_valid,
  input  uart_line_pkg::rx_byte_t rx_byte,
  output logic                    busy
);
  import uart_cmd_pkg::*;
  import uart_line_pkg::*;

  // one counter serves both the reply timeout and the gap
  localparam int CNT_MAX = (`UART_RX_TIMEOUT > `UART_GAP_CYCLES) ?
                           `UART_RX_TIMEOUT : `UART_GAP_CYCLES;
  localparam int CNT_W = $clog2(CNT_MAX);
  localparam logic [CNT_W-1:0] TIMEOUT_LAST = CNT_W'(`UART_RX_TIMEOUT - 1);
  localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(`UART_GAP_CYCLES - 1);

  engine_state_e    state;
  cmd_t             cmd_q;
  rsp_t             rsp_q;
  logic [CNT_W-1:0] cnt;
  logic             timeout_hit;
  logic             reply_hit;

  assign cmd_ready   = (state == S_IDLE);
  assign busy        = (state != S_IDLE);
  assign rsp_valid   = (state == S_RESPOND);
  assign rsp         = rsp_q;
  assign tx_start    = (state == S_HEADER || state == S_DATA) && tx_ready;
  assign tx_byte     = (state == S_DATA) ? cmd_q.wdata : {cmd_q.op, cmd_q.addr};
  assign timeout_hit = (state == S_WAIT_REPLY) && !rx_busy && (cnt == TIMEOUT_LAST);
  assign reply_hit   = (state == S_RECEIVE) && rx_valid;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= S_IDLE;
      cnt   <= '0;
    end
    else
    begin
      cnt <= cnt + 1'b1;   // free running, cleared where a wait begins
      case (state)
        S_IDLE:       if (cmd_valid) state <= S_HEADER;
        S_HEADER:     if (tx_done) state <= (cmd_q.op == OP_WRITE) ? S_DATA : S_WAIT_REPLY;
        S_DATA:       if (tx_done) state <= S_GAP;
        S_WAIT_REPLY: if (rx_busy) state <= S_RECEIVE; else if (timeout_hit) state <= S_RESPOND;
        S_RECEIVE:    if (reply_hit) state <= S_RESPOND; else if (!rx_busy) state <= S_WAIT_REPLY;
        S_RESPOND:    if (rsp_ready) state <= S_GAP;
        S_GAP:        if (cnt == GAP_LAST) state <= S_IDLE;
        default:      state <= S_IDLE;
      endcase
      if (tx_done || (state == S_RESPOND && rsp_ready))
        cnt <= '0;
      else if (state == S_RECEIVE || (state == S_WAIT_REPLY && rx_busy))
        cnt <= cnt;   // a rejected start glitch resumes the timeout where it stood
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && cmd_valid)
      cmd_q <= cmd;
    if (timeout_hit)
    begin
      rsp_q.status <= RSP_TIMEOUT;
      rsp_q.rdata  <= '0;
    end
    else if (reply_hit)
    begin
      rsp_q.status <= rx_byte.parity_ok ? RSP_OK : RSP_PARITY_ERR;
      rsp_q.rdata  <= rx_byte.data;   // the byte is kept even on a parity error
    end
  end

endmodule

/* uart_cmd_input.txt */
// kind (0 write, 1 read, 2 bad offset, 3 back-to-back write, f end), command word, reply byte,
// reply mode (0 good, 1 bad parity, 2 none), expected rdata, rsp status, AXI response
0 9a5c 00 0 00 0 0
1 1300 a7 0 a7 0 0
1 2200 3c 1 3c 1 0
1 4500 5e 2 00 2 0
3 c5a0 00 0 00 0 0
3 8b3f 00 0 00 0 0
3 f17e 00 0 00 0 0
3 9d01 00 0 00 0 0
3 a2c8 00 0 00 0 0
2 00c3 00 0 00 0 2
1 7f00 ff 0 ff 0 0
0 ffff 00 0 00 0 0
f 0000 00 0 00 0 0

/* uart_cmd_pkg.sv */
package uart_cmd_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_e;

  // same layout as bits 15:0 of the AXI write data
  typedef struct packed {
    cmd_op_e    op;
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_t;

  typedef enum logic [1:0] {
    RSP_OK         = 2'd0,
    RSP_PARITY_ERR = 2'd1,
    RSP_TIMEOUT    = 2'd2
  } rsp_status_e;

  typedef struct packed {
    rsp_status_e status;
    logic [7:0]  rdata;
  } rsp_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

endpackage

/* uart_cmd_top.sv */
`timescale 1ns/1ps

module uart_cmd_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     awvalid,
  input  logic [3:0]               awaddr,
  output logic                     awready,
  input  logic                     wvalid,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,
  output logic                     wready,
  output logic                     bvalid,
  output uart_cmd_pkg::axil_resp_e bresp,
  input  logic                     bready,
  input  logic                     arvalid,
  input  logic [3:0]               araddr,
  output logic                     arready,
  output logic                     rvalid,
  output logic [31:0]              rdata,
  output uart_cmd_pkg::axil_resp_e rresp,
  input  logic                     rready,
  input  logic                     rx,
  output logic                     tx
);
  import uart_cmd_pkg::*;
  import uart_line_pkg::*;

  cmd_t       in_cmd;
  logic       in_cmd_valid;
  logic       in_cmd_ready;
  cmd_t       q_cmd;
  logic       q_cmd_valid;
  logic       q_cmd_ready;
  rsp_t       rsp;
  logic       rsp_valid;
  logic       rsp_ready;
  logic       eng_busy;
  logic       any_busy;
  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_ready;
  logic       tx_done;
  logic       rx_busy;
  logic       rx_valid;
  rx_byte_t   rx_byte;

  // queued commands count as busy for the status register
  assign any_busy = eng_busy || q_cmd_valid;

  cmd_axil_slave i_slave (
    .clk       (clk),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awready   (awready),
    .wvalid    (wvalid),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wready    (wready),
    .bvalid    (bvalid),
    .bresp     (bresp),
    .bready    (bready),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arready   (arready),
    .rvalid    (rvalid),
    .rdata     (rdata),
    .rresp     (rresp),
    .rready    (rready),
    .cmd_valid (in_cmd_valid),
    .cmd       (in_cmd),
    .cmd_ready (in_cmd_ready),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .rsp_ready (rsp_ready),
    .busy      (any_busy)
  );

  cmd_fifo i_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_cmd_valid),
    .in_ready  (in_cmd_ready),
    .in_data   (in_cmd),
    .out_valid (q_cmd_valid),
    .out_ready (q_cmd_ready),
    .out_data  (q_cmd)
  );

  uart_cmd_engine i_engine (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (q_cmd_valid),
    .cmd_ready (q_cmd_ready),
    .cmd       (q_cmd),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_ready  (tx_ready),
    .tx_done   (tx_done),
    .rx_busy   (rx_busy),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte),
    .busy      (eng_busy)
  );

  uart_line_tx i_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_byte),
    .ready (tx_ready),
    .done  (tx_done),
    .tx    (tx)
  );

  uart_line_rx i_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .busy     (rx_busy),
    .valid    (rx_valid),
    .byte_out (rx_byte)
  );

endmodule

/* uart_line_pkg.sv */
package uart_line_pkg;

  typedef enum logic [2:0] {
    S_IDLE,
    S_HEADER,
    S_DATA,
    S_WAIT_REPLY,
    S_RECEIVE,
    S_RESPOND,
    S_GAP
  } engine_state_e;

  // one reply frame as seen on rx
  typedef struct packed {
    logic [7:0] data;
    logic       parity_ok;
  } rx_byte_t;

endpackage

/* uart_line_rx.sv */
`timescale 1ns/1ps
`include "uart_cmd_defs.svh"

module uart_line_rx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  output logic                    busy,
  output logic                    valid,
  output uart_line_pkg::rx_byte_t byte_out
);
  localparam int BAUD_W = $clog2(`UART_BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`UART_BAUD_DIV - 1);
  localparam logic [BAUD_W-1:0] BAUD_MID = BAUD_W'(`UART_BAUD_DIV / 2);

  logic              rx_meta;
  logic              rx_sync;
  logic              rx_prev;
  logic              fall;
  logic              mid;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_idx;
  logic [7:0]        shreg;
  logic              parity_ok;

  assign fall = rx_prev && !rx_sync;
  assign mid  = busy && (baud_cnt == BAUD_MID);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      valid    <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      valid <= 1'b0;
      if (!busy)
      begin
        busy     <= fall;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
      else
      begin
        baud_cnt <= (baud_cnt == BAUD_LAST) ? '0 : baud_cnt + 1'b1;
        if (baud_cnt == BAUD_LAST)
          bit_idx <= bit_idx + 1'b1;
        if (mid && bit_idx == 4'd0 && rx_sync)
          busy <= 1'b0;   // start bit gone by mid-bit so it was a glitch
        if (mid && bit_idx == 4'd10)
        begin
          busy  <= 1'b0;
          valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid && bit_idx >= 4'd1 && bit_idx <= 4'd8)
      shreg <= {rx_sync, shreg[7:1]};   // LSB arrives first
    if (mid && bit_idx == 4'd9)
      parity_ok <= ^{shreg, rx_sync};
    if (mid && bit_idx == 4'd10)
    begin
      byte_out.data      <= shreg;
      byte_out.parity_ok <= parity_ok;
    end
  end

endmodule

/* uart_line_tx.sv */
`timescale 1ns/1ps
`include "uart_cmd_defs.svh"

module uart_line_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [7:0] data,
  output logic       ready,
  output logic       done,
  output logic       tx
);
  localparam int BAUD_W = $clog2(`UART_BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`UART_BAUD_DIV - 1);

  logic              active;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_idx;   // 0 start, 1 to 8 data, 9 parity, 10 stop
  logic [9:0]        shreg;     // bits that follow the start bit
  logic              bit_end;

  assign ready   = !active;
  assign bit_end = active && (baud_cnt == BAUD_LAST);
  assign done    = bit_end && (bit_idx == 4'd10);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else if (start && ready)
    begin
      active   <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b0;
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == 4'd10)
        active <= 1'b0;   // line stays at the stop level
      else
      begin
        tx      <= shreg[0];
        bit_idx <= bit_idx + 1'b1;
      end
    end
    else if (active)
      baud_cnt <= baud_cnt + 1'b1;
  end

  // odd parity makes the nine bits hold an odd number of ones
  always_ff @(posedge clk)
  begin
    if (start && ready)
      shreg <= {1'b1, ~^data, data};
    else if (bit_end)
      shreg <= {1'b0, shreg[9:1]};
  end

endmodule
